/* i2c_driver.f */
logic/i2c_pkg.sv
logic/i2c_sequencer.sv
logic/i2c_bit_engine.sv
logic/i2c_driver.sv
bench/i2c_slave_model.sv
bench/i2c_driver_properties.sv
bench/i2c_driver_tb.sv

/* Bender.yml */
package:
  name: i2c_driver

sources:
  - logic/i2c_pkg.sv
  - logic/i2c_sequencer.sv
  - logic/i2c_bit_engine.sv
  - logic/i2c_driver.sv
  - target: test
    files:
      - bench/i2c_slave_model.sv
      - bench/i2c_driver_properties.sv
      - bench/i2c_driver_tb.sv

/* bench/i2c_driver_input.txt */
# op width addr data: op is W or R, width is 8 or 16, addr and data in hex
# data is the byte written for W and the byte expected back for R
W 8 0012 a5
R 8 0012 a5
W 8 0034 3c
W 8 00ff 81
R 8 0034 3c
R 8 00ff 81
W 16 1234 5a
W 16 5634 c3
R 16 1234 5a
R 16 5634 c3
W 16 00aa 0f
R 16 00aa 0f
W 16 ab00 f0
R 16 ab00 f0

/* bench/i2c_driver_tb.sv */
`timescale 1ns/1ps

module i2c_driver_tb;

logic                dri_clk;
logic                rst_n;
logic                i2c_exec;
logic                bit_ctrl;
logic                i2c_rh_wl;
i2c_pkg::word_addr_t i2c_addr;
i2c_pkg::byte_t      i2c_data_w;
i2c_pkg::byte_t      i2c_data_r;
logic                i2c_done;
logic                scl;
wire                 sda;
int                  slave_xfers;
logic                slave_addr_err;
i2c_pkg::word_addr_t slave_waddr;
logic                loaded = 1'b0;

// one entry per line of the input file
bit                  q_rd[$];
bit                  q_wide[$];
i2c_pkg::word_addr_t q_addr[$];
i2c_pkg::byte_t      q_data[$];                 // write data or expected read data

pullup (sda);

i2c_driver i2c_driver_inst (
    .dri_clk    (dri_clk),
    .rst_n      (rst_n),
    .i2c_exec   (i2c_exec),
    .bit_ctrl   (bit_ctrl),
    .i2c_rh_wl  (i2c_rh_wl),
    .i2c_addr   (i2c_addr),
    .i2c_data_w (i2c_data_w),
    .i2c_data_r (i2c_data_r),
    .i2c_done   (i2c_done),
    .scl        (scl),
    .sda        (sda)
);

i2c_slave_model u_slave (
    .scl        (scl),
    .sda        (sda),
    .addr16     (bit_ctrl),
    .xfers      (slave_xfers),
    .addr_err   (slave_addr_err),
    .waddr_seen (slave_waddr)
);

initial begin
    dri_clk = 1'b0;
    forever #5 dri_clk = ~dri_clk;
end

// a 16 bit read is the longest at 205 cycles per line
initial begin
    wait (loaded);
    #(q_rd.size() * 205 * 10 + 2000);
    $display("timeout: the transfers did not finish in time");
    stop_run();
end

// ******************************
// helpers
// ******************************

task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
endtask

task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        stop_run();
    end
endtask

// sum of the phase lengths of one transfer
function automatic int expected_cycles(input bit rd, input bit wide);
    int n;
    n = i2c_pkg::ph_len_addr + i2c_pkg::ph_len_byte;
    if (wide) n += i2c_pkg::ph_len_byte;
    if (rd) n += i2c_pkg::ph_len_addr + i2c_pkg::ph_len_byte;
    else n += i2c_pkg::ph_len_byte;
    return n + i2c_pkg::ph_len_stop;
endfunction

task automatic load_transactions();
    int                  fd;
    string               line;
    byte                 op;
    int                  width;
    i2c_pkg::word_addr_t addr;
    i2c_pkg::byte_t      data;
    fd = $fopen("bench/i2c_driver_input.txt", "r");
    if (fd == 0) begin
        $display("cannot open bench/i2c_driver_input.txt");
        stop_run();
    end
    while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
            if ($sscanf(line, "%c %d %h %h", op, width, addr, data) != 4) begin
                $display("unreadable line in the input file: %s", line);
                stop_run();
            end
            q_rd.push_back(op == "R");
            q_wide.push_back(width == 16);
            q_addr.push_back(addr);
            q_data.push_back(data);
        end
    end
    $fclose(fd);
    if (q_rd.size() == 0) begin
        $display("the input file holds no transactions");
        stop_run();
    end
endtask

task automatic watch_idle_bus();
    repeat (10) begin
        @(posedge dri_clk);
        #1;
        compare_value("i2c_done", 0, i2c_done);
        compare_value("scl", 1, scl);
        compare_value("sda", 1, sda);
    end
endtask

// ******************************
// one transfer
// ******************************

task automatic run_transaction(input int idx, inout i2c_pkg::byte_t last_rd);
    int                  cycles;
    i2c_pkg::word_addr_t exp_waddr;
    i2c_rh_wl  = q_rd[idx];
    bit_ctrl   = q_wide[idx];
    i2c_addr   = q_addr[idx];
    i2c_data_w = q_data[idx];
    i2c_exec   = 1'b1;
    @(posedge dri_clk);                         // accepting edge
    #1;
    i2c_exec = 1'b0;
    cycles   = 0;
    do begin
        @(posedge dri_clk);
        #1;
        cycles++;
    end while (i2c_done !== 1'b1);
    compare_value("i2c_done cycle", expected_cycles(q_rd[idx], q_wide[idx]), cycles);
    if (q_rd[idx]) last_rd = q_data[idx];       // a write keeps the old value
    compare_value("i2c_data_r", last_rd, i2c_data_r);
    assert (slave_xfers == idx + 1 && !slave_addr_err) else begin
        $display("slave saw a wrong device address or a missing START or STOP");
        stop_run();
    end
    // only the lower byte goes out for an 8 bit word address
    exp_waddr = q_wide[idx] ? q_addr[idx] : {8'h00, q_addr[idx][7:0]};
    compare_value("slave word address", exp_waddr, slave_waddr);
    assert (i2c_driver_inst.u_properties.prop_fails == 0) else begin
        $display("a bus property assertion failed during request %0d", idx);
        stop_run();
    end
endtask

initial begin : stimulus
    i2c_pkg::byte_t last_rd;
    rst_n      = 1'b0;
    i2c_exec   = 1'b0;
    bit_ctrl   = 1'b0;
    i2c_rh_wl  = 1'b0;
    i2c_addr   = '0;
    i2c_data_w = '0;
    last_rd    = '0;                            // i2c_data_r out of reset
    load_transactions();
    loaded = 1'b1;
    repeat (4) @(posedge dri_clk);
    #1;
    rst_n = 1'b1;
    watch_idle_bus();
    foreach (q_rd[i]) begin
        run_transaction(i, last_rd);            // next one starts right after done
    end
    if (i2c_driver_inst.u_properties.prop_fails == 0) begin
        $display("Simulation finished: PASS");
        $finish;
    end else begin
        $display("a bus property assertion failed");
        stop_run();
    end
end

endmodule

/* bench/i2c_driver_properties.sv */
`timescale 1ns/1ps

module i2c_driver_properties (
    input logic                 dri_clk,
    input logic                 rst_n,
    input logic                 i2c_done,
    input logic                 scl,
    input i2c_pkg::phase_kind_e kind,       // phase the engine is running
    input logic                 sda_dir
);

int prop_fails = 0;                         // read by the testbench

done_single: assert property (@(posedge dri_clk) disable iff (!rst_n)
    i2c_done |=> !i2c_done)
    else begin
        prop_fails++;
        $error("i2c_done high on two cycles in a row");
    end

scl_idle_high: assert property (@(posedge dri_clk) disable iff (!rst_n)
    (kind == i2c_pkg::ph_idle) |-> scl)
    else begin
        prop_fails++;
        $error("scl low while the engine is idle");
    end

rx_released: assert property (@(posedge dri_clk) disable iff (!rst_n)
    (kind == i2c_pkg::ph_rx_byte) |-> !sda_dir)
    else begin
        prop_fails++;
        $error("master drives sda during a receive byte");
    end

endmodule

bind i2c_driver i2c_driver_properties u_properties (
    .dri_clk  (dri_clk),
    .rst_n    (rst_n),
    .i2c_done (i2c_done),
    .scl      (scl),
    .kind     (cmd.kind),
    .sda_dir  (u_bit_engine.sda_dir)
);

/* bench/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model (
    input  logic                scl,
    inout  wire                 sda,
    input  logic                addr16,         // width of the current word address
    output int                  xfers,          // transfers closed by a STOP
    output logic                addr_err,
    output i2c_pkg::word_addr_t waddr_seen      // word address of the latest transfer
);

logic           sda_low = 1'b0;                 // open drain pull
int             start_cnt = 0;
int             stop_cnt = 0;
i2c_pkg::byte_t mem [0:65535];

assign sda = sda_low ? 1'b0 : 1'bz;

// START and STOP seen as sda moves while scl is high
always @(negedge sda) begin
    if (scl === 1'b1) start_cnt++;
end

always @(posedge sda) begin
    if (scl === 1'b1) stop_cnt++;
end

task automatic wait_start();
    int n;
    n = start_cnt;
    wait (start_cnt != n);
endtask

task automatic wait_stop();
    int n;
    n = stop_cnt;
    wait (stop_cnt != n);
endtask

// a START seen inside the byte means a repeated START
task automatic get_byte(output i2c_pkg::byte_t b, output logic restart);
    int n;
    int i;
    n       = start_cnt;
    restart = 1'b0;
    b       = '0;
    i       = 0;
    while (i < 8 && !restart) begin
        @(posedge scl);
        b = {b[6:0], sda};
        @(negedge scl);
        restart = (start_cnt != n);
        i++;
    end
endtask

// the master lets go one dri_clk after scl falls
task automatic send_ack();
    #12 sda_low = 1'b1;
    @(negedge scl);
    sda_low = 1'b0;
endtask

task automatic send_byte(input i2c_pkg::byte_t b);
    for (int i = 7; i >= 0; i--) begin
        #12 sda_low = !b[i];
        @(negedge scl);
        sda_low = 1'b0;                         // released for the nack slot at the end
    end
endtask

initial begin : slave_seq
    i2c_pkg::byte_t      b;
    i2c_pkg::word_addr_t waddr;
    logic                restart;
    xfers      = 0;
    addr_err   = 1'b0;
    waddr_seen = '0;
    #1;                                         // bus settles out of time zero
    forever begin
        wait_start();
        get_byte(b, restart);
        if (b != {7'b1010000, 1'b0}) addr_err = 1'b1;
        send_ack();
        waddr = '0;
        if (addr16) begin
            get_byte(b, restart);
            waddr[15:8] = b;                    // upper byte comes first
            send_ack();
        end
        get_byte(b, restart);
        waddr[7:0] = b;
        waddr_seen = waddr;
        send_ack();
        get_byte(b, restart);
        if (restart) begin
            get_byte(b, restart);
            if (b != {7'b1010000, 1'b1}) addr_err = 1'b1;
            send_ack();
            send_byte(mem[waddr]);
        end else begin
            mem[waddr] = b;
            send_ack();
        end
        wait_stop();
        xfers++;
    end
end

endmodule

/* logic/i2c_driver.sv */
`timescale 1ns/1ps

module i2c_driver (
    input  logic                dri_clk,        // 4x scl rate
    input  logic                rst_n,

    // request side
    input  logic                i2c_exec,
    input  logic                bit_ctrl,       // 16 or 8 bit word address
    input  logic                i2c_rh_wl,      // 1 = read
    input  i2c_pkg::word_addr_t i2c_addr,
    input  i2c_pkg::byte_t      i2c_data_w,
    output i2c_pkg::byte_t      i2c_data_r,
    output logic                i2c_done,

    // bus
    output logic                scl,
    inout  wire                 sda
);

i2c_pkg::i2c_req_t   req;
i2c_pkg::phase_cmd_t cmd;
logic                phase_done;

// request ports gathered into one word for the sequencer
assign req = '{
    rd:     i2c_rh_wl,
    addr16: bit_ctrl,
    addr:   i2c_addr,
    wdata:  i2c_data_w
};

i2c_sequencer u_sequencer (
    .dri_clk    (dri_clk),
    .rst_n      (rst_n),
    .exec       (i2c_exec),
    .req        (req),
    .phase_done (phase_done),
    .cmd        (cmd)
);

i2c_bit_engine u_bit_engine (
    .dri_clk    (dri_clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .phase_done (phase_done),
    .i2c_data_r (i2c_data_r),
    .i2c_done   (i2c_done),
    .scl        (scl),
    .sda        (sda)
);

endmodule

/* logic/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                dri_clk,
    input  logic                rst_n,
    input  i2c_pkg::phase_cmd_t cmd,
    output logic                phase_done,     // last-but-one cycle of a phase
    output i2c_pkg::byte_t      i2c_data_r,
    output logic                i2c_done,
    output logic                scl,
    inout  wire                 sda
);

i2c_pkg::bit_cnt_t cnt;
i2c_pkg::bit_cnt_t ph_len;
i2c_pkg::byte_t    rx_shift;
logic              last;
logic              is_start;
logic [4:0]        slot;                        // 4 cycle bit slot within the phase
logic [4:0]        bit_slot;                    // slot with the start preamble removed
logic              sda_out;
logic              sda_dir;                     // 1 = master drives sda
logic              sda_in;

// ******************************
// sda tristate
// ******************************

assign sda    = sda_dir ? sda_out : 1'bz;
assign sda_in = sda;

// ******************************
// phase decode
// ******************************

always_comb begin
    case (cmd.kind)
        i2c_pkg::ph_start_byte,
        i2c_pkg::ph_restart_byte: ph_len = i2c_pkg::ph_len_addr;
        i2c_pkg::ph_stop:         ph_len = i2c_pkg::ph_len_stop;
        default:                  ph_len = i2c_pkg::ph_len_byte;
    endcase
end

assign is_start = (cmd.kind == i2c_pkg::ph_start_byte) ||
                  (cmd.kind == i2c_pkg::ph_restart_byte);
assign last     = (cnt == ph_len - 7'd1);
assign slot     = cnt[6:2];
assign bit_slot = is_start ? slot - 5'd1 : slot;

// ******************************
// counter, scl and sda
// ******************************

always_ff @(posedge dri_clk or negedge rst_n) begin
    if (!rst_n) begin
        cnt        <= '0;
        scl        <= 1'b1;
        sda_out    <= 1'b1;
        sda_dir    <= 1'b1;
        phase_done <= 1'b0;
        i2c_done   <= 1'b0;
        i2c_data_r <= '0;
    end else begin
        phase_done <= 1'b0;
        i2c_done   <= 1'b0;
        if (cmd.kind == i2c_pkg::ph_idle) begin
            cnt     <= '0;
            scl     <= 1'b1;                    // bus released
            sda_out <= 1'b1;
            sda_dir <= 1'b1;
        end else begin
            cnt        <= last ? '0 : cnt + 7'd1;
            phase_done <= (cnt == ph_len - 7'd2);
            if (cmd.kind == i2c_pkg::ph_stop) begin
                case (cnt)
                    7'd0: begin
                        sda_dir <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    7'd1: scl     <= 1'b1;
                    7'd3: sda_out <= 1'b1;      // stop condition
                    default: ;
                endcase
                i2c_done <= last;
            end else begin
                if (cnt[1:0] == 2'd1) begin
                    scl <= 1'b1;
                end else if (cnt[1:0] == 2'd3) begin
                    scl <= 1'b0;
                end

                if (cnt[1:0] == 2'd0) begin
                    if (is_start && slot == 5'd0) begin
                        sda_dir <= 1'b1;        // preamble, sda high
                        sda_out <= 1'b1;
                    end else if (cmd.kind == i2c_pkg::ph_rx_byte) begin
                        sda_dir <= 1'b0;        // nack by release too
                        sda_out <= 1'b1;
                    end else if (bit_slot < 5'd8) begin
                        sda_dir <= 1'b1;
                        sda_out <= cmd.tx_byte[3'd7 - bit_slot[2:0]];
                    end else begin
                        sda_dir <= 1'b0;        // ack slot, not checked
                        sda_out <= 1'b1;
                    end
                end

                // start and repeated start, sda falls while scl high
                if ((cmd.kind == i2c_pkg::ph_start_byte && cnt == 7'd1) ||
                    (cmd.kind == i2c_pkg::ph_restart_byte && cnt == 7'd2)) begin
                    sda_out <= 1'b0;
                end

                if (cmd.kind == i2c_pkg::ph_rx_byte && last) begin
                    i2c_data_r <= rx_shift;
                end
            end
        end
    end
end

// msb first, sampled as scl rises
always_ff @(posedge dri_clk) begin
    if (cmd.kind == i2c_pkg::ph_rx_byte && cnt[1:0] == 2'd1 && slot < 5'd8) begin
        rx_shift <= {rx_shift[6:0], sda_in};
    end
end

endmodule

/* logic/i2c_sequencer.sv */
`timescale 1ns/1ps

module i2c_sequencer (
    input  logic                dri_clk,
    input  logic                rst_n,
    input  logic                exec,
    input  i2c_pkg::i2c_req_t   req,
    input  logic                phase_done,     // from bit engine
    output i2c_pkg::phase_cmd_t cmd
);

i2c_pkg::xfer_state_e state;
i2c_pkg::xfer_state_e state_nxt;
i2c_pkg::i2c_req_t    req_q;                    // request held for the transfer
i2c_pkg::phase_cmd_t  cmd_nxt;

// ******************************
// transfer FSM
// ******************************

always_ff @(posedge dri_clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= i2c_pkg::idle;
    end else begin
        state <= state_nxt;
    end
end

// request is only looked at while idle
always_ff @(posedge dri_clk) begin
    if (state == i2c_pkg::idle && exec) begin
        req_q <= req;
    end
end

always_comb begin
    state_nxt = state;
    case (state)
        i2c_pkg::idle: begin
            if (exec) state_nxt = i2c_pkg::dev_addr_wr;
        end
        i2c_pkg::dev_addr_wr: begin
            if (phase_done) begin
                if (req_q.addr16) state_nxt = i2c_pkg::addr_hi;
                else              state_nxt = i2c_pkg::addr_lo;
            end
        end
        i2c_pkg::addr_hi: begin
            if (phase_done) state_nxt = i2c_pkg::addr_lo;
        end
        i2c_pkg::addr_lo: begin
            if (phase_done) begin
                if (req_q.rd) state_nxt = i2c_pkg::dev_addr_rd;
                else          state_nxt = i2c_pkg::data_wr;
            end
        end
        i2c_pkg::data_wr: begin
            if (phase_done) state_nxt = i2c_pkg::stop;
        end
        i2c_pkg::dev_addr_rd: begin
            if (phase_done) state_nxt = i2c_pkg::data_rd;
        end
        i2c_pkg::data_rd: begin
            if (phase_done) state_nxt = i2c_pkg::stop;
        end
        i2c_pkg::stop: begin
            if (phase_done) state_nxt = i2c_pkg::idle;
        end
        default: state_nxt = i2c_pkg::idle;
    endcase
end

// ******************************
// phase command decode
// ******************************

// decoded from the next state so cmd lines up with state
always_comb begin
    cmd_nxt.kind    = i2c_pkg::ph_idle;
    cmd_nxt.tx_byte = '0;
    case (state_nxt)
        i2c_pkg::dev_addr_wr: begin
            cmd_nxt.kind    = i2c_pkg::ph_start_byte;
            cmd_nxt.tx_byte = {i2c_pkg::dev_addr, 1'b0};   // write
        end
        i2c_pkg::addr_hi: begin
            cmd_nxt.kind    = i2c_pkg::ph_tx_byte;
            cmd_nxt.tx_byte = req_q.addr[15:8];
        end
        i2c_pkg::addr_lo: begin
            cmd_nxt.kind    = i2c_pkg::ph_tx_byte;
            cmd_nxt.tx_byte = req_q.addr[7:0];
        end
        i2c_pkg::data_wr: begin
            cmd_nxt.kind    = i2c_pkg::ph_tx_byte;
            cmd_nxt.tx_byte = req_q.wdata;
        end
        i2c_pkg::dev_addr_rd: begin
            cmd_nxt.kind    = i2c_pkg::ph_restart_byte;
            cmd_nxt.tx_byte = {i2c_pkg::dev_addr, 1'b1};   // read
        end
        i2c_pkg::data_rd: cmd_nxt.kind = i2c_pkg::ph_rx_byte;
        i2c_pkg::stop:    cmd_nxt.kind = i2c_pkg::ph_stop;
        default: ;
    endcase
end

always_ff @(posedge dri_clk or negedge rst_n) begin
    if (!rst_n) begin
        cmd <= '{kind: i2c_pkg::ph_idle, tx_byte: '0};
    end else begin
        cmd <= cmd_nxt;
    end
end

endmodule

/* logic/i2c_pkg.sv */
package i2c_pkg;

// ******************************
// widths
// ******************************

typedef logic [7:0]  byte_t;                    // one byte on the bus
typedef logic [15:0] word_addr_t;               // word address inside the device
typedef logic [6:0]  bit_cnt_t;                 // cycle count within a phase

localparam logic [6:0] dev_addr = 7'b1010000;   // fixed slave address

// phase lengths in dri_clk cycles
localparam bit_cnt_t ph_len_byte = 7'd36;       // 8 bits + ack
localparam bit_cnt_t ph_len_addr = 7'd40;       // start + 8 bits + ack
localparam bit_cnt_t ph_len_stop = 7'd17;

// ******************************
// state and phase encodings
// ******************************

typedef enum logic [2:0] {
    idle,
    dev_addr_wr,
    addr_hi,
    addr_lo,
    data_wr,
    dev_addr_rd,
    data_rd,
    stop
} xfer_state_e;

typedef enum logic [2:0] {
    ph_idle,                                    // bus released high
    ph_start_byte,
    ph_restart_byte,
    ph_tx_byte,
    ph_rx_byte,
    ph_stop
} phase_kind_e;

typedef struct packed {
    logic       rd;                             // 1 = read
    logic       addr16;                         // 1 = 16 bit word address
    word_addr_t addr;
    byte_t      wdata;
} i2c_req_t;

typedef struct packed {
    phase_kind_e kind;
    byte_t       tx_byte;
} phase_cmd_t;

endpackage
